//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - design/mem_bus_pkg.sv
  - design/mem_bus_if.sv
  - design/addr_decoder.sv
  - design/mem_interconnect.sv
  - design/wait_timer.sv
  - design/bus_guard_fsm.sv
  - design/sram_slave.sv
  - design/mem_subsystem_top.sv
  - target: test
    files:
      - dv/tb_mem_subsystem.sv

//--- design/addr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module addr_decoder (
   input  mem_bus_pkg::addr_t                   addr,
   input  logic                                 valid,
   output mem_bus_pkg::slave_idx_t              slave_idx,
   output logic [mem_bus_pkg::N_SLAVES-1:0]     slave_valid
);

   import mem_bus_pkg::*;

   ////////////////////
   // Window select
   ////////////////////

   // Top address bits always pick a window
   assign slave_idx = addr[SLAVE_LSB +: SLAVE_IDX_W];

   // One-hot valid mask
   always_comb begin
      slave_valid = '0;
      // Nothing selected while the master is idle
      if (valid) begin
         slave_valid[slave_idx] = 1'b1;
      end
   end

   ////////////////////
   // Checks
   ////////////////////

   // At most one window selected
   always_comb begin
      assert final ($onehot0(slave_valid))
         else $error("slave_valid has more than one bit set");
   end

endmodule

`default_nettype wire

//--- design/bus_guard_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module bus_guard_fsm (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               m_valid,
   input  logic               slave_ready,
   input  mem_bus_pkg::data_t slave_rdata,
   input  logic               expired,
   output logic               m_ready,
   output mem_bus_pkg::data_t m_rdata,
   output logic               bus_error,
   output logic               count_en,
   output logic               clear
);

   import mem_bus_pkg::*;

   guard_state_e state_q;
   guard_state_e state_d;

   // Guard completes the access itself for one cycle
   logic timeout_q;

   ////////////////////
   // State machine
   ////////////////////

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         IDLE: begin
            if (m_valid) begin
               state_d = WAIT;
            end
         end
         // Slave answer or timer whichever comes first
         WAIT: begin
            if (slave_ready || expired) begin
               state_d = DONE;
            end
         end
         DONE: state_d = IDLE;
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q   <= IDLE;
         timeout_q <= 1'b0;
      end else begin
         state_q   <= state_d;
         // Slave answer wins a tie with the timer
         timeout_q <= (state_q == WAIT) && expired && !slave_ready;
      end
   end

   ////////////////////
   // Timer control
   ////////////////////

   // Count from the accepting edge so the error lands on the limit edge
   assign count_en = (state_q == WAIT) || ((state_q == IDLE) && m_valid);
   assign clear    = (state_q == DONE);

   // Response to the master
   assign m_ready   = slave_ready | timeout_q;
   assign m_rdata   = timeout_q ? POISON_DATA : slave_rdata;
   assign bus_error = timeout_q;

   // Error completes the access alone, no late slave answer on top
   assert property (@(posedge clk) disable iff (!rst_n)
      bus_error |-> m_ready && !slave_ready)
      else $error("bus_error while a slave also answered");

   // Single-cycle ready pulse
   assert property (@(posedge clk) disable iff (!rst_n)
      m_ready |=> !m_ready)
      else $error("m_ready held for two cycles");

endmodule

`default_nettype wire

//--- design/mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// One slave-side native memory channel
interface mem_bus_if;

   import mem_bus_pkg::*;

   // Request, driven by the interconnect
   addr_t addr;
   data_t wdata;
   strb_t wstrb;
   logic  valid;

   // Response, driven by the slave
   logic  ready;
   data_t rdata;

   modport master (
      output addr,
      output wdata,
      output wstrb,
      output valid,
      input  ready,
      input  rdata
   );

   modport slave (
      input  addr,
      input  wdata,
      input  wstrb,
      input  valid,
      output ready,
      output rdata
   );

endinterface

`default_nettype wire

//--- design/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

   ////////////////////
   // Bus widths
   ////////////////////

   // Native memory port, one word per access
   localparam int unsigned ADDR_W = 32;
   localparam int unsigned DATA_W = 32;
   localparam int unsigned STRB_W = DATA_W / 8;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   // All strobes zero marks a read
   typedef logic [STRB_W-1:0] strb_t;

   ////////////////////
   // Address map
   ////////////////////

   localparam int unsigned N_SLAVES    = 4;
   localparam int unsigned SLAVE_IDX_W = $clog2(N_SLAVES);
   // Window select sits in the top address bits
   localparam int unsigned SLAVE_LSB   = ADDR_W - SLAVE_IDX_W;

   typedef logic [SLAVE_IDX_W-1:0] slave_idx_t;

   // Each RAM holds 256 words, byte address bits 9:2
   localparam int unsigned RAM_WORDS = 256;
   localparam int unsigned RAM_AW    = $clog2(RAM_WORDS);

   typedef logic [RAM_AW-1:0] ram_idx_t;

   ////////////////////
   // Timing
   ////////////////////

   localparam int unsigned RAM0_WAIT      = 0;
   localparam int unsigned RAM1_WAIT      = 2;
   // Edge at which the guard ends an unanswered access
   localparam int unsigned TIMEOUT_CYCLES = 16;
   localparam int unsigned TIMER_W        = $clog2(TIMEOUT_CYCLES);

   typedef logic [TIMER_W-1:0] timer_cnt_t;

   // Read value handed back on timeout
   localparam data_t POISON_DATA = 32'hDEAD_BEEF;

   // Guard states, DONE lasts one cycle while the master drops valid
   typedef enum logic [1:0] {
      IDLE,
      WAIT,
      DONE
   } guard_state_e;

endpackage

`default_nettype wire

//--- design/mem_interconnect.sv
`timescale 1ns/1ps
`default_nettype none

module mem_interconnect (
   input  mem_bus_pkg::addr_t m_addr,
   input  mem_bus_pkg::data_t m_wdata,
   input  mem_bus_pkg::strb_t m_wstrb,
   input  logic               m_valid,
   output logic               slave_ready,
   output mem_bus_pkg::data_t slave_rdata,
   mem_bus_if.master          sl [mem_bus_pkg::N_SLAVES]
);

   import mem_bus_pkg::*;

   slave_idx_t          slave_idx;
   logic [N_SLAVES-1:0] slave_valid;

   // Responses gathered into plain arrays for the return mux
   logic [N_SLAVES-1:0] ready_vec;
   data_t               rdata_arr [N_SLAVES];

   // Decode the addressed window
   addr_decoder u_decoder (
      .addr        (m_addr),
      .valid       (m_valid),
      .slave_idx   (slave_idx),
      .slave_valid (slave_valid)
   );

   ////////////////////
   // Request fan-out
   ////////////////////

   for (genvar gi = 0; gi < N_SLAVES; gi++) begin : g_chan
      // Same request on every channel
      assign sl[gi].addr  = m_addr;
      assign sl[gi].wdata = m_wdata;
      assign sl[gi].wstrb = m_wstrb;

      // Only the selected channel sees valid
      assign sl[gi].valid = m_valid & slave_valid[gi];

      assign ready_vec[gi] = sl[gi].ready;
      assign rdata_arr[gi] = sl[gi].rdata;

      // At the rising edge of this valid the sampled mask is the old one,
      // so every channel must have been idle
      assert property (@(posedge slave_valid[gi]) slave_valid == '0)
         else $error("channel %0d valid rose while another was active", gi);
   end

   ////////////////////
   // Response mux
   ////////////////////

   // Index is stable for the whole access
   assign slave_ready = ready_vec[slave_idx];
   assign slave_rdata = rdata_arr[slave_idx];

endmodule

`default_nettype wire

//--- design/mem_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top (
   input  logic               clk,
   input  logic               rst_n,
   input  mem_bus_pkg::addr_t m_addr,
   input  mem_bus_pkg::data_t m_wdata,
   input  mem_bus_pkg::strb_t m_wstrb,
   input  logic               m_valid,
   output mem_bus_pkg::data_t m_rdata,
   output logic               m_ready,
   output logic               bus_error
);

   import mem_bus_pkg::*;

   logic  slave_ready;
   data_t slave_rdata;
   logic  count_en;
   logic  clear;
   logic  expired;

   // One channel per address window
   mem_bus_if ch [N_SLAVES] ();

   mem_interconnect u_interconnect (
      .m_addr      (m_addr),
      .m_wdata     (m_wdata),
      .m_wstrb     (m_wstrb),
      .m_valid     (m_valid),
      .slave_ready (slave_ready),
      .slave_rdata (slave_rdata),
      .sl          (ch)
   );

   ////////////////////
   // Slaves
   ////////////////////

   // Window 0, program RAM
   sram_slave #(
      .WAIT_STATES (RAM0_WAIT)
   ) u_ram0 (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (ch[0])
   );

   // Window 1, data RAM with wait states
   sram_slave #(
      .WAIT_STATES (RAM1_WAIT)
   ) u_ram1 (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (ch[1])
   );

   // Windows 2 and 3 never answer, left to the guard
   for (genvar gi = 2; gi < N_SLAVES; gi++) begin : g_empty
      assign ch[gi].ready = 1'b0;
      assign ch[gi].rdata = '0;
   end

   ////////////////////
   // Guard
   ////////////////////

   bus_guard_fsm u_guard (
      .clk         (clk),
      .rst_n       (rst_n),
      .m_valid     (m_valid),
      .slave_ready (slave_ready),
      .slave_rdata (slave_rdata),
      .expired     (expired),
      .m_ready     (m_ready),
      .m_rdata     (m_rdata),
      .bus_error   (bus_error),
      .count_en    (count_en),
      .clear       (clear)
   );

   wait_timer u_timer (
      .clk      (clk),
      .rst_n    (rst_n),
      .count_en (count_en),
      .clear    (clear),
      .expired  (expired)
   );

endmodule

`default_nettype wire

//--- design/sram_slave.sv
`timescale 1ns/1ps
`default_nettype none

module sram_slave #(
   parameter int unsigned WAIT_STATES = 0
) (
   input  logic      clk,
   input  logic      rst_n,
   mem_bus_if.slave  bus
);

   import mem_bus_pkg::*;

   // Wide enough to hold WAIT_STATES, one bit at least
   localparam int unsigned CNT_W = $clog2(WAIT_STATES + 2);

   data_t            mem [RAM_WORDS];
   logic [CNT_W-1:0] wait_cnt;
   logic             ready_q;
   data_t            rdata_q;
   ram_idx_t         word_idx;
   logic             access;
   logic             is_write;

   // Word index from byte address
   assign word_idx = bus.addr[RAM_AW+1:2];
   assign is_write = |bus.wstrb;

   // Last wait state reached, access happens now
   assign access = bus.valid && !ready_q && (wait_cnt == CNT_W'(WAIT_STATES));

   ////////////////////
   // Handshake
   ////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ready_q  <= 1'b0;
         wait_cnt <= '0;
      end else if (ready_q) begin
         // Valid still high here, ignored
         ready_q <= 1'b0;
      end else if (access) begin
         ready_q  <= 1'b1;
         wait_cnt <= '0;
      end else if (bus.valid) begin
         wait_cnt <= wait_cnt + 1'b1;
      end else begin
         wait_cnt <= '0;
      end
   end

   ////////////////////
   // Storage
   ////////////////////

   always_ff @(posedge clk) begin
      if (access) begin
         if (is_write) begin
            // Merge enabled bytes only
            for (int b = 0; b < STRB_W; b++) begin
               if (bus.wstrb[b]) begin
                  mem[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
               end
            end
         end else begin
            rdata_q <= mem[word_idx];
         end
      end
   end

   assign bus.ready = ready_q;
   assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

//--- design/wait_timer.sv
`timescale 1ns/1ps
`default_nettype none

module wait_timer (
   input  logic clk,
   input  logic rst_n,
   input  logic count_en,
   input  logic clear,
   output logic expired
);

   import mem_bus_pkg::*;

   // Last count before the guard steps in
   localparam timer_cnt_t LIMIT = timer_cnt_t'(TIMEOUT_CYCLES - 1);

   timer_cnt_t count_q;

   // Saturating cycle counter
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count_q <= '0;
      end else if (clear) begin
         count_q <= '0;
      end else if (count_en && (count_q != LIMIT)) begin
         count_q <= count_q + 1'b1;
      end
   end

   // Level, held until cleared
   assign expired = (count_q == LIMIT);

endmodule

`default_nettype wire

//--- dv/tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;

   import mem_bus_pkg::*;

   // Run limit covers about 220 accesses of up to TIMEOUT_CYCLES + 2 cycles plus reset
   localparam int unsigned ACCESS_BUDGET = 220;
   localparam int unsigned MAX_CYCLES    = ACCESS_BUDGET * (TIMEOUT_CYCLES + 2) + 40;
   localparam int unsigned N_TESTS       = 5;

   logic  clk;
   logic  rst_n;
   addr_t m_addr;
   data_t m_wdata;
   strb_t m_wstrb;
   logic  m_valid;
   data_t m_rdata;
   logic  m_ready;
   logic  bus_error;

   int          seed;
   int          errors;
   int          checks;
   int          test_errors;
   int unsigned cycles;
   int          lat_cnt;
   int          exp_lat;
   logic        exp_err;
   logic        seen_valid;

   // Byte-wise copy of both RAMs
   logic [7:0] ref_mem [2][RAM_WORDS*4];

   mem_subsystem_top uut (
      .clk       (clk),
      .rst_n     (rst_n),
      .m_addr    (m_addr),
      .m_wdata   (m_wdata),
      .m_wstrb   (m_wstrb),
      .m_valid   (m_valid),
      .m_rdata   (m_rdata),
      .m_ready   (m_ready),
      .bus_error (bus_error)
   );

   ////////////////////
   // Clock and watchdog
   ////////////////////

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Run did not finish within %0d cycles", MAX_CYCLES);
         $display("Simulation FAILED");
         $finish;
      end
   end

   // Edges since valid was first sampled
   // Zero at edge 0
   always @(posedge clk) begin
      if (m_valid && !m_ready) begin
         lat_cnt <= lat_cnt + 1;
      end else begin
         lat_cnt <= 0;
      end
      if (m_valid) begin
         seen_valid <= 1'b1;
      end
   end

   ////////////////////
   // Protocol checks
   ////////////////////

   task automatic log_failure(input string msg);
      errors++;
      $display("%s", msg);
   endtask

   // Quiet outputs until the first request
   // Reset holds from the first edge on
   a_reset_quiet: assert property (@(posedge clk)
      (cycles > 0) && !seen_valid |-> !m_ready && !bus_error)
      else log_failure("m_ready or bus_error high before any request");

   // Ready lands exactly on the window's latency
   a_ready_latency: assert property (@(posedge clk) disable iff (!rst_n)
      m_ready |-> m_valid && (lat_cnt == exp_lat))
      else log_failure($sformatf("m_ready came at edge %0d, not %0d",
                                 $sampled(lat_cnt), exp_lat));

   a_ready_due: assert property (@(posedge clk) disable iff (!rst_n)
      m_valid && (lat_cnt == exp_lat) |-> m_ready)
      else log_failure($sformatf("m_ready missing at edge %0d", exp_lat));

   // Error only on empty windows and with poison data
   a_error_window: assert property (@(posedge clk) disable iff (!rst_n)
      bus_error |-> exp_err && m_ready && (m_rdata == POISON_DATA))
      else log_failure("bus_error without a timeout of an empty window");

   a_error_due: assert property (@(posedge clk) disable iff (!rst_n)
      m_ready && exp_err |-> bus_error)
      else log_failure("empty window completed without bus_error");

   a_error_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      bus_error |=> !bus_error)
      else log_failure("bus_error held for more than one cycle");

   ////////////////////
   // Helpers
   ////////////////////

   function automatic addr_t window_addr(input int win, input int word);
      return (addr_t'(win) << SLAVE_LSB) | addr_t'(word * 4);
   endfunction

   function automatic data_t model_read(input int win, input int word);
      data_t d;
      for (int b = 0; b < 4; b++) begin
         d[8*b +: 8] = ref_mem[win][word*4 + b];
      end
      return d;
   endfunction

   // One handshake entered and left 5 ns after a rising edge
   task automatic bus_access(input int win, input int word, input data_t wdata,
                             input strb_t strb, output data_t rdata);
      exp_lat = (win == 0) ? 1 + RAM0_WAIT : (win == 1) ? 1 + RAM1_WAIT : TIMEOUT_CYCLES;
      exp_err = (win > 1);
      m_addr  = window_addr(win, word);
      m_wdata = wdata;
      m_wstrb = strb;
      m_valid = 1'b1;
      do @(posedge clk); while (!m_ready);
      rdata = m_rdata;
      #5;
      m_valid = 1'b0;
      m_wstrb = '0;
      // Valid stays low for one full cycle
      @(posedge clk);
      #5;
   endtask

   task automatic write_word(input int win, input int word, input data_t data,
                             input strb_t strb);
      data_t unused;
      bus_access(win, word, data, strb, unused);
      if (win < 2) begin
         for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
               ref_mem[win][word*4 + b] = data[8*b +: 8];
            end
         end
      end
   endtask

   task automatic read_check(input int win, input int word);
      data_t got;
      data_t exp;
      bus_access(win, word, '0, '0, got);
      exp = (win < 2) ? model_read(win, word) : POISON_DATA;
      checks++;
      assert (got === exp)
         else log_failure($sformatf("FAIL m_rdata exp %h got %h", exp, got));
   endtask

   task automatic finish_test(input string name);
      $display("test %-12s done, %0d errors", name, errors - test_errors);
      test_errors = errors;
   endtask

   ////////////////////
   // Tests
   ////////////////////

   initial begin
      int    strb_r;
      data_t rnd;
      strb_t strb;
      clk         = 1'b0;
      rst_n       = 1'b0;
      m_addr      = '0;
      m_wdata     = '0;
      m_wstrb     = '0;
      m_valid     = 1'b0;
      seed        = 6;
      errors      = 0;
      checks      = 0;
      test_errors = 0;
      cycles      = 0;
      lat_cnt     = 0;
      exp_lat     = 0;
      exp_err     = 1'b0;
      seen_valid  = 1'b0;

      // Reset for 3 cycles with quiet outputs
      repeat (3) @(posedge clk);
      #5;
      rst_n = 1'b1;
      repeat (4) @(posedge clk);
      checks++;
      assert (!m_ready && !bus_error)
         else log_failure("outputs active after reset");
      #5;
      finish_test("reset");

      // Full words to the program RAM
      for (int w = 0; w < 16; w++) begin
         write_word(0, w, 32'h1000_0000 + w * 32'h0101_0101, 4'hF);
      end
      for (int w = 0; w < 16; w++) begin
         read_check(0, w);
      end
      finish_test("ram0");

      // Data RAM on the same offsets leaves the program RAM untouched
      for (int w = 0; w < 16; w++) begin
         write_word(1, w, 32'hA500_0000 ^ (w * 32'h0011_2233), 4'hF);
      end
      for (int w = 0; w < 16; w++) begin
         read_check(1, w);
      end
      for (int w = 0; w < 16; w++) begin
         read_check(0, w);
      end
      finish_test("ram1");

      // Random partial strobes on both RAMs
      for (int win = 0; win < 2; win++) begin
         for (int w = 32; w < 40; w++) begin
            rnd = $random(seed);
            write_word(win, w, rnd, 4'hF);
            for (int k = 0; k < 4; k++) begin
               rnd    = $random(seed);
               strb_r = $random(seed);
               strb   = strb_t'(strb_r);
               // Keep it a partial write
               if (strb == 4'h0) strb = 4'b0001;
               if (strb == 4'hF) strb = 4'b0110;
               write_word(win, w, rnd, strb);
            end
            read_check(win, w);
         end
      end
      finish_test("strobes");

      // Empty windows time out and the RAMs then answer normally
      read_check(2, 5);
      write_word(3, 7, 32'h1234_5678, 4'hF);
      write_word(2, 9, 32'h0BAD_F00D, 4'h3);
      read_check(3, 1);
      read_check(0, 3);
      read_check(1, 3);
      finish_test("timeout");

      $display("%0d tests, %0d checks, %0d errors", N_TESTS, checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
design/mem_bus_pkg.sv
design/mem_bus_if.sv
design/addr_decoder.sv
design/mem_interconnect.sv
design/wait_timer.sv
design/bus_guard_fsm.sv
design/sram_slave.sv
design/mem_subsystem_top.sv
dv/tb_mem_subsystem.sv
